// ==== decode_pkg.sv ====
// Decode package: RV32I opcodes, instruction word views and control encodings
`default_nettype none

package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // Base integer opcodes plus the custom halt
  typedef enum logic [6:0] {
    OP       = 7'b0110011,
    OP_IMM   = 7'b0010011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    MISC_MEM = 7'b0001111,
    HALT     = 7'h7F
  } opcode_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  // Same bits seen as immediate fields
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } imm_fmt_t;

  typedef union packed {
    r_fmt_t   r;
    imm_fmt_t i;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } aluop_t;

  typedef enum logic [1:0] {SRC_A_RS1, SRC_A_IMM_S, SRC_A_PC} src_a_t;

  typedef enum logic [1:0] {SRC_B_RS1, SRC_B_RS2, SRC_B_IMM, SRC_B_IMM_U} src_b_t;

  typedef enum logic [1:0] {WSRC_NONE, WSRC_PC4, WSRC_IMM_U} wsrc_t;

endpackage

`default_nettype wire

// ==== control_unit.sv ====
// Control unit: opcode decode into register addresses, ALU op and operand selects
`default_nettype none

module control_unit import decode_pkg::*; (
  input  instr_u     instr,
  output reg_idx_t   rs1_addr,
  output reg_idx_t   rs2_addr,
  output reg_idx_t   rd,
  output aluop_t     aluop,
  output src_a_t     src_a,
  output src_b_t     src_b,
  output logic       shamt_sel,
  output wsrc_t      w_src,
  output logic       wen,
  output logic       jump,
  output logic       j_sel,
  output logic       branch,
  output logic       load,
  output logic       store,
  output logic       halt_req,
  output logic       ifence,
  output logic [2:0] branch_type
);

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic aluop_t alu_decode(input logic [2:0] funct3, input logic alt);
    aluop_t op;
    case (funct3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  logic is_shift;

  assign rs1_addr = instr.r.rs1;
  assign rs2_addr = instr.r.rs2;
  assign is_shift = (instr.r.funct3 == 3'b001) || (instr.r.funct3 == 3'b101);

  always_comb begin
    aluop       = ALU_ADD;
    src_a       = SRC_A_RS1;
    src_b       = SRC_B_RS1;
    shamt_sel   = 1'b0;
    w_src       = WSRC_NONE;
    wen         = 1'b0;
    jump        = 1'b0;
    j_sel       = 1'b0;
    branch      = 1'b0;
    load        = 1'b0;
    store       = 1'b0;
    halt_req    = 1'b0;
    ifence      = 1'b0;
    branch_type = 3'b000;
    case (instr.r.opcode)
      LOAD: begin
        src_b = SRC_B_IMM;
        load  = 1'b1;
        wen   = 1'b1;
      end
      STORE: begin
        src_a = SRC_A_IMM_S;
        store = 1'b1;
      end
      AUIPC: begin
        src_a = SRC_A_PC;
        src_b = SRC_B_IMM_U;
        wen   = 1'b1;
      end
      LUI: begin
        w_src = WSRC_IMM_U;
        wen   = 1'b1;
      end
      JAL: begin
        jump  = 1'b1;
        j_sel = 1'b1;
        w_src = WSRC_PC4;
        wen   = 1'b1;
      end
      JALR: begin
        jump  = 1'b1;
        w_src = WSRC_PC4;
        wen   = 1'b1;
      end
      BRANCH: begin
        src_b       = SRC_B_RS2;
        branch      = 1'b1;
        branch_type = instr.r.funct3;
      end
      OP: begin
        src_b = SRC_B_RS2;
        aluop = alu_decode(instr.r.funct3, instr.r.funct7[5]);
        wen   = 1'b1;
      end
      OP_IMM: begin
        // Bit 30 only matters for the right shift
        src_b     = SRC_B_IMM;
        shamt_sel = is_shift;
        aluop     = alu_decode(instr.r.funct3, is_shift && instr.r.funct7[5]);
        wen       = 1'b1;
      end
      MISC_MEM: ifence   = 1'b1;
      HALT:     halt_req = 1'b1;
      default: ;
    endcase
  end

  assign rd = wen ? instr.r.rd : '0;

endmodule

`default_nettype wire

// ==== operand_select.sv ====
// Operand select: immediate extension and routing of ALU sources, write-back and jump parts
`default_nettype none

module operand_select import decode_pkg::*; (
  input  instr_u instr,
  input  word_t  pc,
  input  word_t  rs1_data,
  input  word_t  rs2_data,
  input  src_a_t src_a,
  input  src_b_t src_b,
  input  logic   shamt_sel,
  input  wsrc_t  w_src,
  input  logic   j_sel,
  output word_t  port_a,
  output word_t  port_b,
  output word_t  wdata,
  output word_t  j_base,
  output word_t  j_offset,
  output word_t  imm_sb
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t imm_j;
  word_t shamt;

  assign imm_i = {{20{instr.i.imm_hi[6]}}, instr.i.imm_hi, instr.i.rs2};
  assign imm_s = {{20{instr.i.imm_hi[6]}}, instr.i.imm_hi, instr.i.imm_lo};
  assign imm_u = {instr.i.imm_hi, instr.i.rs2, instr.i.rs1, instr.i.funct3, 12'h000};

  // B and J scramble the upper bits, bit 0 is always zero
  assign imm_sb = {{19{instr.i.imm_hi[6]}}, instr.i.imm_hi[6], instr.i.imm_lo[0],
                   instr.i.imm_hi[5:0], instr.i.imm_lo[4:1], 1'b0};
  assign imm_j  = {{11{instr.i.imm_hi[6]}}, instr.i.imm_hi[6], instr.i.rs1, instr.i.funct3,
                   instr.i.rs2[0], instr.i.imm_hi[5:0], instr.i.rs2[4:1], 1'b0};

  assign shamt = {27'h0, instr.i.rs2};

  always_comb begin
    case (src_a)
      SRC_A_RS1:   port_a = rs1_data;
      SRC_A_IMM_S: port_a = imm_s;
      SRC_A_PC:    port_a = pc;
      default:     port_a = '0;
    endcase
  end

  always_comb begin
    case (src_b)
      SRC_B_RS1: port_b = rs1_data;
      SRC_B_RS2: port_b = rs2_data;
      SRC_B_IMM: port_b = shamt_sel ? shamt : imm_i;
      default:   port_b = imm_u;
    endcase
  end

  always_comb begin
    case (w_src)
      WSRC_PC4:   wdata = pc + 32'd4;
      WSRC_IMM_U: wdata = imm_u;
      default:    wdata = '0;
    endcase
  end

  // JAL is PC relative, JALR is register relative
  assign j_base   = j_sel ? pc : rs1_data;
  assign j_offset = j_sel ? imm_j : imm_i;

endmodule

`default_nettype wire

// ==== fence_tracker.sv ====
// Fence tracker: one-shot cache flush pulse per fence and flush completion status
`default_nettype none

module fence_tracker (
  input  logic CLK,
  input  logic nRST,
  input  logic ifence,
  input  logic pc_en,
  input  logic iflush_done,
  input  logic dflush_done,
  output logic icache_flush,
  output logic dcache_flush,
  output logic iflushed,
  output logic dflushed
);

  logic ifence_reg;
  logic flush_pulse;

  // Previous fence flag, so a run of fences flushes once
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifence_reg <= 1'b0;
    end else if (pc_en) begin
      ifence_reg <= ifence;
    end
  end

  assign flush_pulse  = ifence && !ifence_reg;
  assign icache_flush = flush_pulse;
  assign dcache_flush = flush_pulse;

  // Status bits drop on the pulse and rise once each cache reports done
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      iflushed <= 1'b1;
      dflushed <= 1'b1;
    end else if (flush_pulse) begin
      iflushed <= 1'b0;
      dflushed <= 1'b0;
    end else begin
      if (iflush_done && pc_en) iflushed <= 1'b1;
      if (dflush_done && pc_en) dflushed <= 1'b1;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    (flush_pulse && pc_en) |=> !flush_pulse);

endmodule

`default_nettype wire

// ==== id_ex_register.sv ====
// ID/EX pipeline register with bubble insertion, hold and load
`default_nettype none

module id_ex_register import decode_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       halt,
  input  logic       pc_en,
  input  logic       stall,
  input  logic       id_ex_flush,
  input  aluop_t     aluop,
  input  word_t      port_a,
  input  word_t      port_b,
  input  word_t      wdata,
  input  word_t      j_base,
  input  word_t      j_offset,
  input  word_t      imm_sb,
  input  word_t      pc,
  input  reg_idx_t   rd,
  input  logic       wen,
  input  logic       jump,
  input  logic       j_sel,
  input  logic       branch,
  input  logic       load,
  input  logic       store,
  input  logic       halt_req,
  input  logic       ifence,
  input  logic [2:0] branch_type,
  output aluop_t     ex_aluop,
  output word_t      ex_port_a,
  output word_t      ex_port_b,
  output word_t      ex_wdata,
  output word_t      ex_j_base,
  output word_t      ex_j_offset,
  output word_t      ex_imm_sb,
  output word_t      ex_pc,
  output reg_idx_t   ex_rd,
  output logic       ex_wen,
  output logic       ex_jump,
  output logic       ex_j_sel,
  output logic       ex_branch,
  output logic       ex_load,
  output logic       ex_store,
  output logic       ex_halt,
  output logic       ex_ifence,
  output logic [2:0] ex_branch_type
);

  localparam int unsigned PAYLOAD_W = 7 * $bits(word_t) + $bits(reg_idx_t) + 8 + 3;

  logic                 bubble;
  logic [PAYLOAD_W-1:0] d;
  logic [PAYLOAD_W-1:0] q;

  assign bubble = halt || (pc_en && (id_ex_flush || stall));

  assign d = {port_a, port_b, wdata, j_base, j_offset, imm_sb, pc, rd,
              wen, jump, j_sel, branch, load, store, halt_req, ifence, branch_type};

  // Bubble wins over load, otherwise hold while pc_en is low
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q        <= '0;
      ex_aluop <= ALU_ADD;
    end else if (bubble) begin
      q        <= '0;
      ex_aluop <= ALU_ADD;
    end else if (pc_en) begin
      q        <= d;
      ex_aluop <= aluop;
    end
  end

  assign {ex_port_a, ex_port_b, ex_wdata, ex_j_base, ex_j_offset, ex_imm_sb, ex_pc, ex_rd,
          ex_wen, ex_jump, ex_j_sel, ex_branch, ex_load, ex_store, ex_halt, ex_ifence,
          ex_branch_type} = q;

  // Nothing writes back the cycle after a halt
  assert property (@(posedge CLK) disable iff (!nRST) halt |=> !ex_wen);

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
// Decode stage top: control decode, operand routing, fence tracking and ID/EX register
`default_nettype none

module decode_stage import decode_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       halt,
  input  logic       pc_en,
  input  logic       stall,
  input  logic       id_ex_flush,
  input  logic       iflush_done,
  input  logic       dflush_done,
  input  word_t      instr,
  input  word_t      pc,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  output reg_idx_t   rs1_addr,
  output reg_idx_t   rs2_addr,
  output logic       halt_req,
  output logic       icache_flush,
  output logic       dcache_flush,
  output logic       iflushed,
  output logic       dflushed,
  output aluop_t     ex_aluop,
  output word_t      ex_port_a,
  output word_t      ex_port_b,
  output word_t      ex_wdata,
  output word_t      ex_j_base,
  output word_t      ex_j_offset,
  output word_t      ex_imm_sb,
  output word_t      ex_pc,
  output reg_idx_t   ex_rd,
  output logic       ex_wen,
  output logic       ex_jump,
  output logic       ex_j_sel,
  output logic       ex_branch,
  output logic       ex_load,
  output logic       ex_store,
  output logic       ex_halt,
  output logic       ex_ifence,
  output logic [2:0] ex_branch_type
);

  instr_u     instr_w;
  reg_idx_t   rd;
  aluop_t     aluop;
  src_a_t     src_a;
  src_b_t     src_b;
  wsrc_t      w_src;
  logic       shamt_sel;
  logic       wen;
  logic       jump;
  logic       j_sel;
  logic       branch;
  logic       load;
  logic       store;
  logic       ifence;
  logic [2:0] branch_type;
  word_t      port_a;
  word_t      port_b;
  word_t      wdata;
  word_t      j_base;
  word_t      j_offset;
  word_t      imm_sb;

  assign instr_w = instr;

  control_unit u_control_unit (
    .instr(instr_w), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd(rd),
    .aluop(aluop), .src_a(src_a), .src_b(src_b), .shamt_sel(shamt_sel),
    .w_src(w_src), .wen(wen), .jump(jump), .j_sel(j_sel), .branch(branch),
    .load(load), .store(store), .halt_req(halt_req), .ifence(ifence),
    .branch_type(branch_type)
  );

  operand_select u_operand_select (
    .instr(instr_w), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .src_a(src_a), .src_b(src_b), .shamt_sel(shamt_sel), .w_src(w_src),
    .j_sel(j_sel), .port_a(port_a), .port_b(port_b), .wdata(wdata),
    .j_base(j_base), .j_offset(j_offset), .imm_sb(imm_sb)
  );

  fence_tracker u_fence_tracker (
    .CLK(CLK), .nRST(nRST), .ifence(ifence), .pc_en(pc_en),
    .iflush_done(iflush_done), .dflush_done(dflush_done),
    .icache_flush(icache_flush), .dcache_flush(dcache_flush),
    .iflushed(iflushed), .dflushed(dflushed)
  );

  id_ex_register u_id_ex_register (
    .CLK(CLK), .nRST(nRST), .halt(halt), .pc_en(pc_en), .stall(stall),
    .id_ex_flush(id_ex_flush), .aluop(aluop), .port_a(port_a), .port_b(port_b),
    .wdata(wdata), .j_base(j_base), .j_offset(j_offset), .imm_sb(imm_sb),
    .pc(pc), .rd(rd), .wen(wen), .jump(jump), .j_sel(j_sel), .branch(branch),
    .load(load), .store(store), .halt_req(halt_req), .ifence(ifence),
    .branch_type(branch_type), .ex_aluop(ex_aluop), .ex_port_a(ex_port_a),
    .ex_port_b(ex_port_b), .ex_wdata(ex_wdata), .ex_j_base(ex_j_base),
    .ex_j_offset(ex_j_offset), .ex_imm_sb(ex_imm_sb), .ex_pc(ex_pc),
    .ex_rd(ex_rd), .ex_wen(ex_wen), .ex_jump(ex_jump), .ex_j_sel(ex_j_sel),
    .ex_branch(ex_branch), .ex_load(ex_load), .ex_store(ex_store),
    .ex_halt(ex_halt), .ex_ifence(ex_ifence), .ex_branch_type(ex_branch_type)
  );

endmodule

`default_nettype wire

// ==== tb_decode_model.svh ====
// Decode reference model: predicted ID/EX contents for one instruction, PC and register data
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_FENCE  = 7'b0001111;
localparam logic [6:0] OPC_HALT   = 7'h7F;

typedef struct packed {
  logic [3:0]  aluop;
  logic [31:0] port_a, port_b, wdata, j_base, j_offset, imm_sb, pc;
  logic [4:0]  rd;
  logic        wen, jump, j_sel, branch, load, store, halt, ifence;
  logic [2:0]  branch_type;
} ex_fields_t;

// ALU codes ADD 0, SUB 1, SLL 2, SLT 3, SLTU 4, XOR 5, SRL 6, SRA 7, OR 8, AND 9
function automatic logic [3:0] alu_code(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? 4'd1 : 4'd0;
    3'd1:    return 4'd2;
    3'd2:    return 4'd3;
    3'd3:    return 4'd4;
    3'd4:    return 4'd5;
    3'd5:    return alt ? 4'd7 : 4'd6;
    3'd6:    return 4'd8;
    default: return 4'd9;
  endcase
endfunction

function automatic ex_fields_t predict_ex(input logic [31:0] i, input logic [31:0] pc,
                                          input logic [31:0] rs1, input logic [31:0] rs2);
  ex_fields_t  e;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic        shift;
  imm_i = {{20{i[31]}}, i[31:20]};
  imm_u = {i[31:12], 12'h000};
  shift = (i[14:12] == 3'd1) || (i[14:12] == 3'd5);
  e = '0;
  e.pc = pc;
  e.imm_sb = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
  // Default routing is rs1 on both ports and a register-relative jump
  e.port_a = rs1;
  e.port_b = rs1;
  e.j_base = rs1;
  e.j_offset = imm_i;
  case (i[6:0])
    OPC_LOAD: begin
      e.port_b = imm_i;
      e.load = 1'b1;
      e.wen = 1'b1;
    end
    OPC_STORE: begin
      e.port_a = {{20{i[31]}}, i[31:25], i[11:7]};
      e.store = 1'b1;
    end
    OPC_AUIPC: begin
      e.port_a = pc;
      e.port_b = imm_u;
      e.wen = 1'b1;
    end
    OPC_LUI: begin
      e.wdata = imm_u;
      e.wen = 1'b1;
    end
    OPC_JAL: begin
      e.jump = 1'b1;
      e.j_sel = 1'b1;
      e.wdata = pc + 32'd4;
      e.wen = 1'b1;
      e.j_base = pc;
      e.j_offset = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
    end
    OPC_JALR: begin
      e.jump = 1'b1;
      e.wdata = pc + 32'd4;
      e.wen = 1'b1;
    end
    OPC_BRANCH: begin
      e.port_b = rs2;
      e.branch = 1'b1;
      e.branch_type = i[14:12];
    end
    OPC_OP: begin
      e.port_b = rs2;
      e.aluop = alu_code(i[14:12], i[30]);
      e.wen = 1'b1;
    end
    OPC_OP_IMM: begin
      // Shifts take the zero-extended shamt field
      e.port_b = shift ? {27'h0, i[24:20]} : imm_i;
      e.aluop = alu_code(i[14:12], shift && i[30]);
      e.wen = 1'b1;
    end
    OPC_FENCE: e.ifence = 1'b1;
    OPC_HALT:  e.halt = 1'b1;
    default: ;
  endcase
  if (e.wen) e.rd = i[11:7];
  return e;
endfunction

`endif

// ==== tb_decode_stage.sv ====
// Decode stage testbench: random instructions and hazard controls checked against a model
`default_nettype none

module tb_decode_stage;

  localparam int NUM_ITERS  = 2000;
  localparam int CLK_PERIOD = 4;
  localparam int TIMEOUT    = (NUM_ITERS + 16) * CLK_PERIOD * 2;

  `include "tb_decode_model.svh"

  logic        CLK;
  logic        nRST;
  logic        halt;
  logic        pc_en;
  logic        stall;
  logic        id_ex_flush;
  logic        iflush_done;
  logic        dflush_done;
  logic [31:0] instr, pc, rs1_data, rs2_data;
  logic [4:0]  rs1_addr, rs2_addr, ex_rd;
  logic        halt_req, icache_flush, dcache_flush, iflushed, dflushed;
  logic [3:0]  ex_aluop;
  logic [31:0] ex_port_a, ex_port_b, ex_wdata, ex_j_base, ex_j_offset, ex_imm_sb, ex_pc;
  logic        ex_wen, ex_jump, ex_j_sel, ex_branch, ex_load, ex_store, ex_halt, ex_ifence;
  logic [2:0]  ex_branch_type;

  integer     seed = 39649;
  int         errors;
  int         checks;
  ex_fields_t exp_q;
  logic       ifence_q;
  logic       iflushed_m;
  logic       dflushed_m;

  decode_stage u_decode_stage (.*);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: simulation did not finish within %0d time units", TIMEOUT);
    $display("Checks failed");
    $finish;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Biased toward decoded opcodes, the last slot repeats the previous word
  task automatic pick_instr();
    logic [31:0] r;
    logic [31:0] body;
    r = $random(seed);
    body = $random(seed);
    case (r[3:0])
      4'd0, 4'd1:   instr = {body[31:7], OPC_OP};
      4'd2, 4'd3:   instr = {body[31:7], OPC_OP_IMM};
      4'd4:         instr = {body[31:7], OPC_LOAD};
      4'd5:         instr = {body[31:7], OPC_STORE};
      4'd6:         instr = {body[31:7], OPC_BRANCH};
      4'd7:         instr = {body[31:7], OPC_JAL};
      4'd8:         instr = {body[31:7], OPC_JALR};
      4'd9:         instr = {body[31:7], OPC_LUI};
      4'd10:        instr = {body[31:7], OPC_AUIPC};
      4'd11, 4'd12: instr = {body[31:7], OPC_FENCE};
      4'd13:        instr = {body[31:7], OPC_HALT};
      4'd14:        instr = body;
      default: ;
    endcase
  endtask

  task automatic drive_inputs(input logic clean);
    logic [31:0] r;
    pick_instr();
    pc = $random(seed) & 32'hFFFF_FFFC;
    rs1_data = $random(seed);
    rs2_data = $random(seed);
    r = $random(seed);
    iflush_done = (r[13:12] == 2'd0);
    dflush_done = (r[15:14] == 2'd0);
    if (clean) begin
      pc_en = 1'b1;
      stall = 1'b0;
      id_ex_flush = 1'b0;
      halt = 1'b0;
    end else begin
      pc_en = (r[1:0] != 2'd0);
      stall = (r[4:2] == 3'd0);
      id_ex_flush = (r[7:5] == 3'd0);
      halt = (r[11:8] == 4'd0);
    end
  endtask

  task automatic check_comb();
    logic pulse;
    pulse = (instr[6:0] == OPC_FENCE) && !ifence_q;
    check("rs1_addr", 32'(rs1_addr), 32'(instr[19:15]));
    check("rs2_addr", 32'(rs2_addr), 32'(instr[24:20]));
    check("halt_req", 32'(halt_req), 32'(instr[6:0] == OPC_HALT));
    check("icache_flush", 32'(icache_flush), 32'(pulse));
    check("dcache_flush", 32'(dcache_flush), 32'(pulse));
  endtask

  // Expected state after the coming rising edge
  task automatic advance_model();
    logic fence;
    logic pulse;
    fence = (instr[6:0] == OPC_FENCE);
    pulse = fence && !ifence_q;
    if (halt || (pc_en && (id_ex_flush || stall))) begin
      exp_q = '0;
    end else if (pc_en) begin
      exp_q = predict_ex(instr, pc, rs1_data, rs2_data);
    end
    if (pulse) begin
      iflushed_m = 1'b0;
      dflushed_m = 1'b0;
    end else begin
      if (iflush_done && pc_en) iflushed_m = 1'b1;
      if (dflush_done && pc_en) dflushed_m = 1'b1;
    end
    if (pc_en) ifence_q = fence;
  endtask

  task automatic check_state();
    check("ex_aluop", 32'(ex_aluop), 32'(exp_q.aluop));
    check("ex_port_a", ex_port_a, exp_q.port_a);
    check("ex_port_b", ex_port_b, exp_q.port_b);
    check("ex_wdata", ex_wdata, exp_q.wdata);
    check("ex_j_base", ex_j_base, exp_q.j_base);
    check("ex_j_offset", ex_j_offset, exp_q.j_offset);
    check("ex_imm_sb", ex_imm_sb, exp_q.imm_sb);
    check("ex_pc", ex_pc, exp_q.pc);
    check("ex_rd", 32'(ex_rd), 32'(exp_q.rd));
    check("ex_wen", 32'(ex_wen), 32'(exp_q.wen));
    check("ex_jump", 32'(ex_jump), 32'(exp_q.jump));
    check("ex_j_sel", 32'(ex_j_sel), 32'(exp_q.j_sel));
    check("ex_branch", 32'(ex_branch), 32'(exp_q.branch));
    check("ex_load", 32'(ex_load), 32'(exp_q.load));
    check("ex_store", 32'(ex_store), 32'(exp_q.store));
    check("ex_halt", 32'(ex_halt), 32'(exp_q.halt));
    check("ex_ifence", 32'(ex_ifence), 32'(exp_q.ifence));
    check("ex_branch_type", 32'(ex_branch_type), 32'(exp_q.branch_type));
    check("iflushed", 32'(iflushed), 32'(iflushed_m));
    check("dflushed", 32'(dflushed), 32'(dflushed_m));
  endtask

  initial begin
    errors = 0;
    checks = 0;
    nRST = 1'b0;
    halt = 1'b0;
    pc_en = 1'b0;
    stall = 1'b0;
    id_ex_flush = 1'b0;
    iflush_done = 1'b0;
    dflush_done = 1'b0;
    instr = '0;
    pc = '0;
    rs1_data = '0;
    rs2_data = '0;
    exp_q = '0;
    ifence_q = 1'b0;
    iflushed_m = 1'b1;
    dflushed_m = 1'b1;
    repeat (4) @(negedge CLK);
    nRST = 1'b1;
    // Reset state, an all-zero word is not a fence
    check_state();
    check_comb();
    // First half runs clean, second half with random hazard controls
    for (int n = 0; n < NUM_ITERS; n++) begin
      drive_inputs(n < NUM_ITERS / 2);
      #1;
      check_comb();
      advance_model();
      @(negedge CLK);
      check_state();
    end
    $display("Decode stage run: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== decode_stage.f ====
+incdir+.
decode_pkg.sv
control_unit.sv
operand_select.sv
fence_tracker.sv
id_ex_register.sv
decode_stage.sv
tb_decode_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim_decode_stage.log

if ! verilator --binary --timing --assert -j 0 --top-module tb_decode_stage \
    -f decode_stage.f -o sim_decode_stage; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_decode_stage > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
